//--- all.f
+incdir+verification
verilog/zpage_pkg.sv
verilog/zbus_decode.sv
verilog/port_regs.sv
verilog/window_pager.sv
verilog/dos_ctl.sv
verilog/addr_mapper.sv
verilog/zpage_top.sv
verification/tb_zpage.sv

//--- Bender.yml
package:
  name: zpage

sources:
  - verilog/zpage_pkg.sv
  - verilog/zbus_decode.sv
  - verilog/port_regs.sv
  - verilog/window_pager.sv
  - verilog/dos_ctl.sv
  - verilog/addr_mapper.sv
  - verilog/zpage_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_zpage.sv

//--- verification/zpage_ref.svh
////////////////////////////////////////////////////////////
// expected mapping of a Z80 memory access, from the mirrored
// register state of the testbench; included inside tb_zpage
////////////////////////////////////////////////////////////
`ifndef ZPAGE_REF_SVH
`define ZPAGE_REF_SVH

// ROM or RAM for one access
// word is the page word of the addressed window in the active bank
function automatic bit access_is_rom(input logic [15:0] addr, input bit pager,
	input logic [7:0] word);
	if (pager)
		return !word[7];
	return addr[15:14] == 2'd0;
endfunction

// ROM page pins
// classic mode picks BASIC or DOS by bit 1, 128K or 48K by bit 0
function automatic logic [4:0] rom_page_of(input bit pager, input logic [7:0] word,
	input bit dos_flag, input bit rom_bit);
	if (pager)
		return word[4:0];
	return {3'b000, !dos_flag, rom_bit};
endfunction

// RAM page for one access
function automatic logic [6:0] ram_page_of(input logic [15:0] addr, input bit pager,
	input logic [7:0] word, input logic [7:0] reg_7ffd);
	if (pager)
		return word[6:0];
	case (addr[15:14])
		2'd1: return 7'd5;
		2'd2: return 7'd2;
		2'd3: return {4'b0000, reg_7ffd[2:0]};
		default: return 7'd0;
	endcase
endfunction

`endif

//--- verification/tb_zpage.sv
////////////////////////////////////////////////////////////
// testbench for the Z80 paging subsystem
// drives bus cycles, mirrors the registers, checks the mapping
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_zpage;

	localparam int  num_tests   = 5;
	localparam time watchdog_ns = num_tests * 2000;

	logic        fclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic        iorq_n;
	logic        mreq_n;
	logic        m1_n;
	logic        rd_n;
	logic        wr_n;
	logic        csrom;
	logic        romoe_n;
	logic [4:0]  rompg;
	logic [6:0]  ram_page;
	logic        dos;

	// mirrored register state
	logic [7:0]  m_7ffd;
	bit          m_pager;
	bit          m_dos;
	logic [7:0]  m_words [4][2];

	// expected values handed to the checker
	bit          check_req;
	logic [15:0] exp_addr;
	bit          exp_is_rom;
	logic [4:0]  exp_rompg;
	logic [6:0]  exp_ram_page;

	int          errors;
	int          checks;
	int          tests_run;
	int          test_errors_at_start;
	string       test_name;

	`include "zpage_ref.svh"

	zpage_top dut0 (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.m1_n     (m1_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rompg    (rompg),
		.ram_page (ram_page),
		.dos      (dos)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////
	// bus tasks start and end on a falling edge
	////////////////////////////////////////////////////////////
	task automatic apply_reset();
		rst_n  = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (3) @(negedge fclk);
		rst_n  = 1'b1;
		m_7ffd  = 8'h00;
		m_pager = 1'b0;
		m_dos   = 1'b0;
		for (int w = 0; w < 4; w++)
		begin
			// window 0 boots into ROM page 0, others into RAM page w
			m_words[w][0] = (w == 0) ? 8'h00 : (8'h80 | 8'(w));
			m_words[w][1] = m_words[w][0];
		end
		@(negedge fclk);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a      = addr;
		d      = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(negedge fclk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(negedge fclk);
		if (addr[7:0] == 8'hFD && !addr[15])
		begin
			if (!m_7ffd[5])
				m_7ffd = data;
		end
		else if (addr[7:0] == 8'hF7)
			m_words[addr[15:14]][m_7ffd[4]] = data;
		else if (addr[7:0] == 8'h77)
			m_pager = data[0];
	endtask

	task automatic fetch(input logic [15:0] addr);
		a      = addr;
		mreq_n = 1'b0;
		m1_n   = 1'b0;
		rd_n   = 1'b0;
		repeat (3) @(negedge fclk);
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		rd_n   = 1'b1;
		repeat (2) @(negedge fclk);
		// RAM window exit wins over DOS entry
		if (addr[15:8] >= 8'h40)
			m_dos = 1'b0;
		else if (addr[15:8] == 8'h3D && m_7ffd[4])
			m_dos = 1'b1;
	endtask

	task automatic mem_read(input logic [15:0] addr);
		logic [7:0] word;
		word         = m_words[addr[15:14]][m_7ffd[4]];
		exp_addr     = addr;
		exp_is_rom   = access_is_rom(addr, m_pager, word);
		exp_rompg    = rom_page_of(m_pager, word, m_dos, m_7ffd[4]);
		exp_ram_page = ram_page_of(addr, m_pager, word, m_7ffd);
		a      = addr;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		@(posedge fclk);
		check_req = 1'b1;
		repeat (2) @(negedge fclk);
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		@(negedge fclk);
	endtask

	// one read at a random offset in each window
	task automatic check_window_reads();
		logic [15:0] addr;
		for (int w = 0; w < 4; w++)
		begin
			addr = 16'($urandom);
			addr[15:14] = w[1:0];
			mem_read(addr);
		end
	endtask

	task automatic check_dos();
		checks++;
		if (dos !== m_dos)
		begin
			$display("ERR dos: expected %h, actual %h", m_dos, dos);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_errors_at_start)
			$display("test %0d %s: ok", tests_run, test_name);
		else
			$display("test %0d %s: %0d errors", tests_run, test_name,
				errors - test_errors_at_start);
	endtask

	////////////////////////////////////////////////////////////
	// output checker on the falling edge
	////////////////////////////////////////////////////////////
	always @(negedge fclk)
		if (check_req)
		begin
			check_req = 1'b0;
			checks++;
			if (csrom !== exp_is_rom)
			begin
				$display("ERR csrom at %h: expected %h, actual %h", exp_addr, exp_is_rom,
					csrom);
				errors++;
			end
			if (romoe_n !== !exp_is_rom)
			begin
				$display("ERR romoe_n at %h: expected %h, actual %h", exp_addr, !exp_is_rom,
					romoe_n);
				errors++;
			end
			if (exp_is_rom)
			begin
				if (rompg !== exp_rompg)
				begin
					$display("ERR rompg at %h: expected %h, actual %h", exp_addr,
						exp_rompg, rompg);
					errors++;
				end
			end
			else if (ram_page !== exp_ram_page)
			begin
				$display("ERR ram_page at %h: expected %h, actual %h", exp_addr, exp_ram_page,
					ram_page);
				errors++;
			end
		end

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired before all tests finished");
		$display("Done: errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int unsigned seed;
		logic [7:0]  data;
		seed = 32'h6a88bd60;
		void'($urandom(seed));
		rst_n     = 1'b0;
		a         = 16'h0000;
		d         = 8'h00;
		iorq_n    = 1'b1;
		mreq_n    = 1'b1;
		m1_n      = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		check_req = 1'b0;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		@(negedge fclk);

		start_test("reset mapping");
		apply_reset();
		for (int w = 0; w < 4; w++)
			mem_read({w[1:0], 14'h0000});
		finish_test();

		start_test("7ffd writes and lock");
		apply_reset();
		repeat (4)
		begin
			data = 8'($urandom) & 8'hDF;
			io_write(16'h7FFD, data);
			check_window_reads();
		end
		io_write(16'h7FFD, 8'($urandom) | 8'h20);
		check_window_reads();
		// lock is set so nothing may change now
		repeat (3)
		begin
			io_write(16'h7FFD, 8'($urandom));
			check_window_reads();
		end
		finish_test();

		start_test("dos switching");
		apply_reset();
		io_write(16'h7FFD, 8'h10);
		mem_read(16'h0000);
		fetch(16'h3D2A);
		check_dos();
		mem_read(16'h0100);
		fetch(16'h8123);
		check_dos();
		mem_read(16'h0000);
		io_write(16'h7FFD, 8'h00);
		fetch(16'h3D00);
		check_dos();
		mem_read(16'h0000);
		finish_test();

		start_test("atm page words");
		apply_reset();
		io_write(16'h0077, 8'h01);
		// reset page words seen through the ATM mapping
		check_window_reads();
		for (int bank = 0; bank < 2; bank++)
		begin
			io_write(16'h7FFD, 8'(bank << 4));
			for (int w = 0; w < 4; w++)
			begin
				// alternate RAM and ROM views over windows and banks
				data = 8'($urandom);
				data[7] = w[0] ^ bank[0];
				io_write({w[1:0], 6'b000000, 8'hF7}, data);
			end
		end
		for (int bank = 0; bank < 2; bank++)
		begin
			io_write(16'h7FFD, 8'(bank << 4));
			check_window_reads();
		end
		finish_test();

		start_test("pager off and on");
		io_write(16'h0077, 8'h00);
		check_window_reads();
		io_write(16'h0077, 8'h01);
		check_window_reads();
		io_write(16'h7FFD, 8'h00);
		check_window_reads();
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/zpage_top.sv
////////////////////////////////////////////////////////////
// Z80 memory paging subsystem, top level
// bus decode, paging registers, DOS flag and address mapper
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zpage_top (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        csrom,
	output logic        romoe_n,
	output logic [4:0]  rompg,
	output logic [6:0]  ram_page,
	output logic        dos
);
	import zpage_pkg::*;

	logic                p7ffd_wr;
	logic                atm_wr;
	logic                pen_wr;
	logic                fetch_stb;
	logic [7:0]          wr_data;
	logic [win_bits-1:0] wr_win;
	logic [7:0]          fetch_hi;
	logic [2:0]          p7ffd_ram;
	logic                rom_sel;
	logic                pager_on;
	page_word_u          win_page [num_windows];

	zbus_decode u_decode (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.a         (a),
		.d         (d),
		.iorq_n    (iorq_n),
		.mreq_n    (mreq_n),
		.m1_n      (m1_n),
		.wr_n      (wr_n),
		.p7ffd_wr  (p7ffd_wr),
		.atm_wr    (atm_wr),
		.pen_wr    (pen_wr),
		.fetch_stb (fetch_stb),
		.wr_data   (wr_data),
		.wr_win    (wr_win),
		.fetch_hi  (fetch_hi)
	);

	port_regs u_ports (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.p7ffd_wr  (p7ffd_wr),
		.pen_wr    (pen_wr),
		.wr_data   (wr_data),
		.p7ffd_ram (p7ffd_ram),
		.rom_sel   (rom_sel),
		.pager_on  (pager_on)
	);

	// one pager per 16K window
	for (genvar i = 0; i < num_windows; i++)
	begin : g_win
		window_pager #(
			.win_index (i)
		) u_pager (
			.fclk    (fclk),
			.rst_n   (rst_n),
			.atm_wr  (atm_wr),
			.wr_win  (wr_win),
			.wr_data (wr_data),
			.rom_sel (rom_sel),
			.page    (win_page[i])
		);
	end

	dos_ctl u_dos (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.fetch_stb (fetch_stb),
		.fetch_hi  (fetch_hi),
		.rom_sel   (rom_sel),
		.dos       (dos)
	);

	addr_mapper u_mapper (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.a         (a),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.pager_on  (pager_on),
		.p7ffd_ram (p7ffd_ram),
		.rom_sel   (rom_sel),
		.dos       (dos),
		.pages     (win_page),
		.csrom     (csrom),
		.romoe_n   (romoe_n),
		.rompg     (rompg),
		.ram_page  (ram_page)
	);

endmodule

`default_nettype wire

//--- verilog/addr_mapper.sv
////////////////////////////////////////////////////////////
// maps each Z80 memory access to a ROM or RAM page
// classic 128K layout or ATM window pages when the pager is on
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module addr_mapper (
	input  logic                                fclk,
	input  logic                                rst_n,
	input  logic [15:0]                         a,
	input  logic                                mreq_n,
	input  logic                                rd_n,
	input  logic                                pager_on,
	input  logic [2:0]                          p7ffd_ram,
	input  logic                                rom_sel,
	input  logic                                dos,
	input  zpage_pkg::page_word_u               pages [zpage_pkg::num_windows],
	output logic                                csrom,
	output logic                                romoe_n,
	output logic [zpage_pkg::rom_page_bits-1:0] rompg,
	output logic [zpage_pkg::ram_page_bits-1:0] ram_page
);
	import zpage_pkg::*;

	logic [win_bits-1:0]      win;
	page_word_u               pw;
	logic                     is_rom;
	logic [rom_page_bits-1:0] rom_next;
	logic [ram_page_bits-1:0] ram_next;

	////////////////////////////////////////////////////////////
	// page lookup
	////////////////////////////////////////////////////////////
	always_comb
	begin
		win      = a[15 -: win_bits];
		pw       = pages[win];
		is_rom   = 1'b0;
		rom_next = '0;
		ram_next = '0;
		if (pager_on)
		begin
			is_rom   = !pw.ram.is_ram;
			rom_next = pw.rom.rom_page;
			ram_next = pw.ram.ram_page;
		end
		else
		begin
			case (win)
				2'd0:
				begin
					// bit 1 picks BASIC over DOS
					is_rom   = 1'b1;
					rom_next = {{(rom_page_bits-2){1'b0}}, !dos, rom_sel};
				end
				2'd1: ram_next = classic_win1_page;
				2'd2: ram_next = classic_win2_page;
				default: ram_next = ram_page_bits'(p7ffd_ram);
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// registered outputs
	////////////////////////////////////////////////////////////
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			csrom   <= 1'b0;
			romoe_n <= 1'b1;
		end
		else
		begin
			csrom   <= !mreq_n && is_rom;
			romoe_n <= !(!mreq_n && is_rom && !rd_n);
		end

	// page pins hold between accesses
	always_ff @(posedge fclk)
		if (!mreq_n)
		begin
			if (is_rom)
				rompg <= rom_next;
			else
				ram_page <= ram_next;
		end

endmodule

`default_nettype wire

//--- verilog/dos_ctl.sv
////////////////////////////////////////////////////////////
// DOS ROM flag, switched by M1 fetch addresses
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dos_ctl (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       fetch_stb,
	input  logic [7:0] fetch_hi,
	input  logic       rom_sel,
	output logic       dos
);
	import zpage_pkg::*;

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			dos <= 1'b0;
		else if (fetch_stb)
		begin
			// leaving to RAM wins over entry
			if (fetch_hi >= ram_window_limit_hi)
				dos <= 1'b0;
			else if (fetch_hi == dos_entry_hi && rom_sel)
				dos <= 1'b1;
		end

	a_dos_on_fetch: assert property (@(posedge fclk) disable iff (!rst_n)
		!fetch_stb |=> $stable(dos));

endmodule

`default_nettype wire

//--- verilog/window_pager.sv
////////////////////////////////////////////////////////////
// page words of one 16K window, one per 7FFD ROM bank
// instantiated once per window with win_index set
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module window_pager #(
	parameter int win_index = 0
) (
	input  logic                           fclk,
	input  logic                           rst_n,
	input  logic                           atm_wr,
	input  logic [zpage_pkg::win_bits-1:0] wr_win,
	input  logic [7:0]                     wr_data,
	input  logic                           rom_sel,
	output zpage_pkg::page_word_u          page
);
	import zpage_pkg::*;

	// window 0 boots into ROM, the rest into RAM
	localparam page_word_u reset_word = (win_index == 0) ?
		page_reset_rom : page_reset_ram(win_index);

	page_word_u bank [2];
	logic       win_hit;

	assign win_hit = atm_wr && (wr_win == win_bits'(win_index));

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			bank[0] <= reset_word;
			bank[1] <= reset_word;
		end
		else if (win_hit)
		begin
			bank[rom_sel] <= wr_data;
		end

	// a ROM bit change swaps the visible bank
	assign page = bank[rom_sel];

endmodule

`default_nettype wire

//--- verilog/port_regs.sv
////////////////////////////////////////////////////////////
// 7FFD paging register with sticky lock, and pager enable
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module port_regs (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       p7ffd_wr,
	input  logic       pen_wr,
	input  logic [7:0] wr_data,
	output logic [2:0] p7ffd_ram,
	output logic       rom_sel,
	output logic       pager_on
);
	import zpage_pkg::*;

	logic [7:0] p7ffd;

	// lock stays set until reset
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			p7ffd    <= 8'h00;
			pager_on <= 1'b0;
		end
		else
		begin
			if (p7ffd_wr && !p7ffd[p7ffd_lock_bit])
				p7ffd <= wr_data;
			if (pen_wr)
				pager_on <= wr_data[0];
		end

	assign p7ffd_ram = p7ffd[p7ffd_ram_lsb +: 3];
	assign rom_sel   = p7ffd[p7ffd_rom_bit];

	a_lock_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		p7ffd[p7ffd_lock_bit] |=> $stable(p7ffd));

endmodule

`default_nettype wire

//--- verilog/zbus_decode.sv
////////////////////////////////////////////////////////////
// Z80 bus decoder: turns I/O writes and M1 fetches into
// one-cycle strobes with the data and address fields latched
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module zbus_decode (
	input  logic                          fclk,
	input  logic                          rst_n,
	input  logic [15:0]                   a,
	input  logic [7:0]                    d,
	input  logic                          iorq_n,
	input  logic                          mreq_n,
	input  logic                          m1_n,
	input  logic                          wr_n,
	output logic                          p7ffd_wr,
	output logic                          atm_wr,
	output logic                          pen_wr,
	output logic                          fetch_stb,
	output logic [7:0]                    wr_data,
	output logic [zpage_pkg::win_bits-1:0] wr_win,
	output logic [7:0]                    fetch_hi
);
	import zpage_pkg::*;

	logic iorq_r;
	logic wr_r;
	logic mreq_r;
	logic m1_r;
	logic io_prev;
	logic fetch_prev;
	logic io_act;
	logic fetch_act;
	logic io_start;
	logic fetch_start;
	logic hit_7ffd;
	logic hit_atm;
	logic hit_pen;

	// one sampling stage on the control lines
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			iorq_r     <= 1'b1;
			wr_r       <= 1'b1;
			mreq_r     <= 1'b1;
			m1_r       <= 1'b1;
			io_prev    <= 1'b0;
			fetch_prev <= 1'b0;
		end
		else
		begin
			iorq_r     <= iorq_n;
			wr_r       <= wr_n;
			mreq_r     <= mreq_n;
			m1_r       <= m1_n;
			io_prev    <= io_act;
			fetch_prev <= fetch_act;
		end

	assign io_act      = !iorq_r && !wr_r;
	assign fetch_act   = !mreq_r && !m1_r;
	// first cycle only, a long cycle counts once
	assign io_start    = io_act && !io_prev;
	assign fetch_start = fetch_act && !fetch_prev;

	assign hit_7ffd = (a[7:0] == port_7ffd_lo) && (a[15] == port_7ffd_a15);
	assign hit_atm  = (a[7:0] == port_atm_lo);
	assign hit_pen  = (a[7:0] == port_pen_lo);

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			p7ffd_wr  <= 1'b0;
			atm_wr    <= 1'b0;
			pen_wr    <= 1'b0;
			fetch_stb <= 1'b0;
		end
		else
		begin
			p7ffd_wr  <= io_start && hit_7ffd;
			atm_wr    <= io_start && hit_atm;
			pen_wr    <= io_start && hit_pen;
			fetch_stb <= fetch_start;
		end

	// payload travels with the strobes
	always_ff @(posedge fclk)
	begin
		if (io_start)
		begin
			wr_data <= d;
			wr_win  <= a[15 -: win_bits];
		end
		if (fetch_start)
			fetch_hi <= a[15:8];
	end

	a_port_onehot: assert property (@(posedge fclk) disable iff (!rst_n)
		$onehot0({p7ffd_wr, atm_wr, pen_wr}));

endmodule

`default_nettype wire

//--- verilog/zpage_pkg.sv
////////////////////////////////////////////////////////////
// shared constants and the page word type of the memory pager
// imported by every block of the paging subsystem
////////////////////////////////////////////////////////////
`default_nettype none

package zpage_pkg;

	// port address codes, low byte
	localparam logic [7:0] port_7ffd_lo  = 8'hFD;
	localparam logic [7:0] port_atm_lo   = 8'hF7;
	localparam logic [7:0] port_pen_lo   = 8'h77;
	localparam logic       port_7ffd_a15 = 1'b0;

	localparam int num_windows   = 4;
	localparam int win_bits      = 2;
	localparam int ram_page_bits = 7;
	localparam int rom_page_bits = 5;

	// dos entry and exit areas, address high byte
	localparam logic [7:0] dos_entry_hi        = 8'h3D;
	localparam logic [7:0] ram_window_limit_hi = 8'h40;

	localparam logic [ram_page_bits-1:0] classic_win1_page = 7'd5;
	localparam logic [ram_page_bits-1:0] classic_win2_page = 7'd2;

	// 7FFD field positions
	localparam int p7ffd_ram_lsb  = 0;
	localparam int p7ffd_rom_bit  = 4;
	localparam int p7ffd_lock_bit = 5;

	typedef struct packed {
		logic                     is_ram;
		logic [ram_page_bits-1:0] ram_page;
	} ram_view_t;

	typedef struct packed {
		logic                     is_ram;
		logic [1:0]               unused;
		logic [rom_page_bits-1:0] rom_page;
	} rom_view_t;

	// is_ram picks the valid view
	typedef union packed {
		ram_view_t ram;
		rom_view_t rom;
	} page_word_u;

	localparam page_word_u page_reset_rom = 8'h00;

	function automatic page_word_u page_reset_ram(input int unsigned idx);
		page_word_u w;
		w.ram.is_ram   = 1'b1;
		w.ram.ram_page = ram_page_bits'(idx);
		return w;
	endfunction

endpackage

`default_nettype wire
